//--- rtl/espi_pkg.sv
`default_nettype none

package espi_pkg;

    localparam int char_max_bits = 16;
    localparam int char_len_w    = 4;

    typedef logic [char_max_bits-1:0] spi_char_t;   // short chars sit in the low bits
    typedef logic [char_len_w-1:0]    char_len_t;   // highest bit number of a char

    typedef struct packed {
        logic      enable;
        logic      cpol;
        logic      cpha;
        logic      cspol;       // 1: cs active low
        logic      rev;         // 1: msb first
        char_len_t char_len;    // 3, 7, 11 or 15
    } espi_cfg_t;

    typedef struct packed {
        char_len_t char_len;    // length the char was received with
        spi_char_t data;
    } rx_entry_t;

    typedef struct packed {
        logic overrun;          // sticky
        logic underrun;         // sticky
        logic rx_nonempty;
        logic tx_empty;
    } espi_status_t;

    localparam logic [1:0] reg_ctrl   = 2'd0;
    localparam logic [1:0] reg_status = 2'd1;
    localparam logic [1:0] reg_txdata = 2'd2;
    localparam logic [1:0] reg_rxdata = 2'd3;

    // ones in bits 0 up to and including len
    function automatic spi_char_t char_mask(char_len_t len);
        spi_char_t ones;
        ones = '1;
        return ~((ones << len) << 1);
    endfunction

endpackage

`default_nettype wire

//--- rtl/espi_char_fifo.sv
`default_nettype none

module espi_char_fifo #(
    parameter type entry_t = logic [15:0],
    parameter int  depth   = 4
) (
    input  wire    S_SYSCLK,
    input  wire    S_RESETN,
    input  wire    push,
    input  wire    entry_t din,
    input  wire    pop,
    output entry_t dout,
    output logic   full,
    output logic   empty
);

    localparam int aw = $clog2(depth);

    entry_t        mem [depth];
    logic [aw-1:0] wr_ptr;
    logic [aw-1:0] rd_ptr;
    logic [aw:0]   count;
    logic          do_push;
    logic          do_pop;

    assign full    = (count == (aw+1)'(depth));
    assign empty   = (count == '0);
    assign do_push = push && !full;     // drop when full
    assign do_pop  = pop && !empty;     // ignore when empty
    assign dout    = mem[rd_ptr];       // head is always visible

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;    // wraps, depth is a power of two
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge S_SYSCLK) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    a_count_bound: assert property (
        @(posedge S_SYSCLK) disable iff (!S_RESETN)
        count <= (aw+1)'(depth)
    );

endmodule

`default_nettype wire

//--- rtl/espi_slave_regs.sv
`default_nettype none

module espi_slave_regs import espi_pkg::*; (
    input  wire            S_SYSCLK,
    input  wire            S_RESETN,
    input  wire            wr,
    input  wire            rd,
    input  wire [1:0]      addr,
    input  wire [15:0]     wdata,
    output logic [15:0]    rdata,
    output logic           rvalid,
    output espi_cfg_t      cfg,
    output logic           tx_push,
    output spi_char_t      tx_wchar,
    input  wire            tx_full,
    input  wire            tx_empty,
    output logic           rx_pop,
    input  wire rx_entry_t rx_entry,
    input  wire            rx_empty,
    input  wire            rx_full,
    input  wire            rx_push,
    input  wire            underrun
);

    espi_cfg_t    wr_cfg;
    espi_status_t status;
    espi_status_t clr;
    logic         underrun_flag;
    logic         overrun_flag;

    always_comb begin
        wr_cfg = espi_cfg_t'(wdata[$bits(espi_cfg_t)-1:0]);
        if (wr_cfg.char_len[1:0] != 2'b11) begin
            wr_cfg.char_len = 4'd7;     // illegal length falls back to 8 bits
        end
    end

    assign clr = espi_status_t'(wdata[$bits(espi_status_t)-1:0]);

    assign status = '{
        overrun:     overrun_flag,
        underrun:    underrun_flag,
        rx_nonempty: !rx_empty,
        tx_empty:    tx_empty
    };

    assign tx_push  = wr && (addr == reg_txdata) && !tx_full;
    assign tx_wchar = wdata;
    assign rx_pop   = rd && (addr == reg_rxdata) && !rx_empty;

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            cfg           <= '{enable: 1'b0, cpol: 1'b0, cpha: 1'b0, cspol: 1'b0,
                               rev: 1'b0, char_len: 4'd7};
            underrun_flag <= 1'b0;
            overrun_flag  <= 1'b0;
            rvalid        <= 1'b0;
        end else begin
            rvalid <= rd;
            if (wr && (addr == reg_ctrl)) begin
                cfg <= wr_cfg;
            end
            if (wr && (addr == reg_status)) begin
                if (clr.underrun) begin
                    underrun_flag <= 1'b0;      // write one to clear
                end
                if (clr.overrun) begin
                    overrun_flag <= 1'b0;
                end
            end
            // a new error in the same cycle wins over the clear
            if (underrun) begin
                underrun_flag <= 1'b1;
            end
            if (rx_push && rx_full) begin
                overrun_flag <= 1'b1;           // queue dropped the char
            end
        end
    end

    always_ff @(posedge S_SYSCLK) begin
        if (rd) begin
            case (addr)
                reg_ctrl:   rdata <= 16'(cfg);
                reg_status: rdata <= 16'(status);
                reg_rxdata: rdata <= rx_empty ? 16'd0 :
                                     (rx_entry.data & char_mask(rx_entry.char_len));
                default:    rdata <= 16'd0;     // txdata is write only
            endcase
        end
    end

    a_no_wr_rd: assert property (
        @(posedge S_SYSCLK) disable iff (!S_RESETN)
        !(wr && rd)
    );

endmodule

`default_nettype wire

//--- rtl/espi_slave_char_trx.sv
`default_nettype none

module espi_slave_char_trx import espi_pkg::*; (
    input  wire            S_SYSCLK,
    input  wire            S_RESETN,
    input  wire espi_cfg_t cfg,
    input  wire spi_char_t tx_char,
    input  wire            tx_empty,
    output logic           tx_pop,
    output logic           underrun,
    output logic           char_done,
    output rx_entry_t      rx_entry,
    input  wire            spi_cs,
    input  wire            spi_sck,
    input  wire            spi_mosi,
    output logic           spi_miso,
    output logic           spi_miso_oe
);

    logic [1:0] cs_sync;
    logic [1:0] sck_sync;
    logic [1:0] mosi_sync;
    logic       sck_d;
    logic       active;
    logic       active_d;
    logic       start;
    logic       rise;
    logic       fall;
    logic       first_edge;
    logic       second_edge;
    logic       sample_edge;
    logic       shift_edge;
    logic       last_sample;
    char_len_t  bit_cnt;
    char_len_t  first_bit;
    char_len_t  last_bit;
    char_len_t  next_bit;
    spi_char_t  tx_reg;
    spi_char_t  rx_acc;
    spi_char_t  rx_next;

    // two flop synchronizers, sck gets one more stage for edge detect
    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            cs_sync   <= '0;
            sck_sync  <= '0;
            mosi_sync <= '0;
            sck_d     <= 1'b0;
        end else begin
            cs_sync   <= {cs_sync[0], spi_cs};
            sck_sync  <= {sck_sync[0], spi_sck};
            mosi_sync <= {mosi_sync[0], spi_mosi};
            sck_d     <= sck_sync[1];
        end
    end

    assign active = cfg.enable && (cfg.cspol ? !cs_sync[1] : cs_sync[1]);

    assign rise        = sck_sync[1] && !sck_d;
    assign fall        = !sck_sync[1] && sck_d;
    assign first_edge  = cfg.cpol ? fall : rise;    // leaving idle level
    assign second_edge = cfg.cpol ? rise : fall;
    assign sample_edge = active && (cfg.cpha ? second_edge : first_edge);
    assign shift_edge  = active && (cfg.cpha ? first_edge : second_edge);

    assign first_bit   = cfg.rev ? cfg.char_len : '0;
    assign last_bit    = cfg.rev ? '0 : cfg.char_len;
    assign last_sample = sample_edge && (bit_cnt == last_bit);

    always_comb begin
        if (bit_cnt == last_bit) begin
            next_bit = first_bit;           // wrap into the next char
        end else if (cfg.rev) begin
            next_bit = bit_cnt - 1'b1;
        end else begin
            next_bit = bit_cnt + 1'b1;
        end
    end

    always_comb begin
        rx_next          = rx_acc;
        rx_next[bit_cnt] = mosi_sync[1];
    end

    // new char when cs goes active and right after each finished char
    assign start    = active && (!active_d || char_done);
    assign tx_pop   = start && !tx_empty;
    assign underrun = start && tx_empty;

    assign spi_miso    = tx_reg[bit_cnt];
    assign spi_miso_oe = active;

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            active_d  <= 1'b0;
            char_done <= 1'b0;
            bit_cnt   <= '0;
        end else begin
            active_d  <= active;
            char_done <= last_sample;
            if (!active) begin
                // cpha 1 parks on the last bit so the first edge wraps to bit one
                bit_cnt <= cfg.cpha ? last_bit : first_bit;
            end else if (shift_edge) begin
                bit_cnt <= next_bit;
            end
        end
    end

    always_ff @(posedge S_SYSCLK) begin
        if (start) begin
            tx_reg <= tx_empty ? '0 : tx_char;   // zeros on underrun
        end
        if (!active) begin
            rx_acc <= '0;                       // partial char is dropped
        end else if (last_sample) begin
            rx_acc            <= '0;
            rx_entry.data     <= rx_next & char_mask(cfg.char_len);
            rx_entry.char_len <= cfg.char_len;
        end else if (sample_edge) begin
            rx_acc <= rx_next;
        end
    end

    a_done_pulse: assert property (
        @(posedge S_SYSCLK) disable iff (!S_RESETN)
        char_done |=> !char_done
    );

    a_cfg_stable: assert property (
        @(posedge S_SYSCLK) disable iff (!S_RESETN)
        active && $past(active) |-> $stable({cfg.cpol, cfg.cpha, cfg.rev, cfg.char_len})
    );

endmodule

`default_nettype wire

//--- rtl/espi_slave_top.sv
`default_nettype none

module espi_slave_top import espi_pkg::*; #(
    parameter int tx_depth = 4,
    parameter int rx_depth = 4
) (
    input  wire         S_SYSCLK,
    input  wire         S_RESETN,
    input  wire         wr,
    input  wire         rd,
    input  wire [1:0]   addr,
    input  wire [15:0]  wdata,
    output logic [15:0] rdata,
    output logic        rvalid,
    input  wire         spi_cs,
    input  wire         spi_sck,
    input  wire         spi_mosi,
    output logic        spi_miso,
    output logic        spi_miso_oe
);

    espi_cfg_t cfg;
    spi_char_t tx_wchar;
    spi_char_t tx_head;
    rx_entry_t rx_in;
    rx_entry_t rx_head;
    logic      tx_push;
    logic      tx_pop;
    logic      tx_full;
    logic      tx_empty;
    logic      rx_pop;
    logic      rx_full;
    logic      rx_empty;
    logic      char_done;       // also the rx push
    logic      underrun;

    espi_slave_regs u_regs (
        .S_SYSCLK, .S_RESETN,
        .wr, .rd, .addr, .wdata, .rdata, .rvalid,
        .cfg,
        .tx_push, .tx_wchar, .tx_full, .tx_empty,
        .rx_pop, .rx_entry(rx_head), .rx_empty, .rx_full,
        .rx_push(char_done), .underrun
    );

    espi_char_fifo #(.entry_t(spi_char_t), .depth(tx_depth)) u_tx_fifo (
        .S_SYSCLK, .S_RESETN,
        .push(tx_push), .din(tx_wchar),
        .pop(tx_pop), .dout(tx_head),
        .full(tx_full), .empty(tx_empty)
    );

    espi_char_fifo #(.entry_t(rx_entry_t), .depth(rx_depth)) u_rx_fifo (
        .S_SYSCLK, .S_RESETN,
        .push(char_done), .din(rx_in),
        .pop(rx_pop), .dout(rx_head),
        .full(rx_full), .empty(rx_empty)
    );

    espi_slave_char_trx u_trx (
        .S_SYSCLK, .S_RESETN,
        .cfg,
        .tx_char(tx_head), .tx_empty, .tx_pop, .underrun,
        .char_done, .rx_entry(rx_in),
        .spi_cs, .spi_sck, .spi_mosi, .spi_miso, .spi_miso_oe
    );

endmodule

`default_nettype wire

//--- dv/espi_spi_master_model.sv
`default_nettype none

module espi_spi_master_model (
    output logic cs,
    output logic sck,
    output logic mosi,
    input  wire  miso
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int half_ns = 50;    // sck half period

    initial begin
        cs   = 1'b0;    // inactive for the reset cspol
        sck  = 1'b0;
        mosi = 1'b0;
    end

    task automatic idle(input logic cpol, input logic cspol);
        cs   = cspol;
        sck  = cpol;
        mosi = 1'b0;
    endtask

    task automatic select(input logic cspol);
        cs = ~cspol;
        #(2 * half_ns);     // slave loads its first char meanwhile
    endtask

    task automatic deselect(input logic cspol);
        #(half_ns);
        cs = cspol;
        #(2 * half_ns);
    endtask

    task automatic xfer_char(input logic cpol, input logic cpha, input logic rev,
                             input logic [3:0] len, input logic [15:0] word,
                             output logic [15:0] got);
        logic [3:0] idx;
        int         k;
        got = '0;
        for (k = 0; k <= int'(len); k++) begin
            idx = rev ? len - 4'(k) : 4'(k);    // msb first counts down
            if (!cpha) begin
                mosi = word[idx];
                #(half_ns);
                sck      = ~cpol;
                got[idx] = miso;    // leading edge samples
                #(half_ns);
                sck = cpol;
            end else begin
                #(half_ns);
                sck  = ~cpol;
                mosi = word[idx];
                #(half_ns);
                sck      = cpol;
                got[idx] = miso;    // trailing edge samples
            end
        end
    endtask

endmodule

`default_nettype wire

//--- dv/tb_espi_slave.sv
`default_nettype none

module tb_espi_slave import espi_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int tx_depth   = 4;
    localparam int rx_depth   = 4;
    localparam int max_cycles = 20000;  // 40 frames x 16 bits x 10 cycles, doubled plus margin

    logic        S_SYSCLK;
    logic        S_RESETN;
    logic        wr;
    logic        rd;
    logic [1:0]  addr;
    logic [15:0] wdata;
    logic [15:0] rdata;
    logic        rvalid;
    wire         spi_cs;
    wire         spi_sck;
    wire         spi_mosi;
    logic        spi_miso;
    logic        spi_miso_oe;

    logic [15:0] exp_q[$];
    logic [15:0] got_q[$];
    string       name_q[$];
    logic [15:0] mosi_words[$];
    logic [15:0] tx_words[$];
    logic        cur_cpol;
    logic        cur_cpha;
    logic        cur_cspol;
    logic        cur_rev;
    logic [3:0]  cur_len;
    int          cycles = 0;
    logic        oe_seen = 1'b0;

    espi_slave_top #(.tx_depth(tx_depth), .rx_depth(rx_depth)) DUT (
        .S_SYSCLK, .S_RESETN, .wr, .rd, .addr, .wdata, .rdata, .rvalid,
        .spi_cs, .spi_sck, .spi_mosi, .spi_miso, .spi_miso_oe
    );

    espi_spi_master_model master (.cs(spi_cs), .sck(spi_sck), .mosi(spi_mosi), .miso(spi_miso));

    initial begin
        S_SYSCLK = 1'b0;
        forever #5 S_SYSCLK = ~S_SYSCLK;
    end

    task automatic stop_fail(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    always @(posedge S_SYSCLK) begin
        while (got_q.size() > 0) begin
            assert (got_q[0] === exp_q[0])
            else stop_fail($sformatf("CHECK FAILED %s: expected %h, actual %h",
                                     name_q[0], exp_q[0], got_q[0]));
            void'(name_q.pop_front());
            void'(exp_q.pop_front());
            void'(got_q.pop_front());
        end
    end

    always @(posedge S_SYSCLK) begin
        cycles++;
        if (cycles > max_cycles) begin
            stop_fail("timeout: the run went past its cycle limit");
        end
        if (spi_miso_oe) begin
            oe_seen = 1'b1;
        end
    end

    task automatic post(input string name, input logic [15:0] exp, input logic [15:0] got);
        name_q.push_back(name);
        exp_q.push_back(exp);
        got_q.push_back(got);
    endtask

    // wire order only decides where each bit lands, the char sits right-aligned
    function automatic logic [15:0] expect_rx(input logic [15:0] word, input logic [3:0] len,
                                              input logic rev);
        logic [15:0] res;
        logic [3:0]  pos;
        int          k;
        res = '0;
        for (k = 0; k <= int'(len); k++) begin
            pos      = rev ? len - 4'(k) : 4'(k);
            res[pos] = word[pos];
        end
        return res;
    endfunction

    function automatic logic [15:0] expect_miso(input logic [15:0] queued, input logic empty,
                                                input logic [3:0] len);
        return empty ? 16'd0 : expect_rx(queued, len, 1'b1);   // zeros on underrun
    endfunction

    function automatic logic [15:0] ctrl_word(input logic en);
        return {7'd0, en, cur_cpol, cur_cpha, cur_cspol, cur_rev, cur_len};
    endfunction

    task automatic host_write(input logic [1:0] a, input logic [15:0] d);
        @(posedge S_SYSCLK);
        #1;
        wr    = 1'b1;
        addr  = a;
        wdata = d;
        @(posedge S_SYSCLK);
        #1;
        wr = 1'b0;
    endtask

    task automatic host_read(input logic [1:0] a, output logic [15:0] d);
        @(posedge S_SYSCLK);
        #1;
        rd   = 1'b1;
        addr = a;
        @(posedge S_SYSCLK);
        #1;
        rd = 1'b0;
        assert (rvalid) else stop_fail("rvalid did not come one cycle after a read");
        d = rdata;
    endtask

    task automatic configure(input logic cpol, input logic cpha, input logic cspol,
                             input logic rev, input logic [3:0] len);
        {cur_cpol, cur_cpha, cur_cspol, cur_rev, cur_len} = {cpol, cpha, cspol, rev, len};
        host_write(reg_ctrl, ctrl_word(1'b0));  // idle levels change while disabled
        master.idle(cpol, cspol);
        repeat (4) @(posedge S_SYSCLK);
        host_write(reg_ctrl, ctrl_word(1'b1));
        tx_words.delete();
        mosi_words.delete();
    endtask

    task automatic run_frame(input string name, input int n_chars);
        logic [15:0] got;
        logic [15:0] queued;
        int          i;
        for (i = 0; i < tx_words.size(); i++) begin
            host_write(reg_txdata, tx_words[i]);
        end
        oe_seen = 1'b0;
        master.select(cur_cspol);
        for (i = 0; i < n_chars; i++) begin
            queued = 16'd0;
            if (i < tx_words.size()) begin
                queued = tx_words[i];
            end
            master.xfer_char(cur_cpol, cur_cpha, cur_rev, cur_len, mosi_words[i], got);
            post({name, " miso"}, expect_miso(queued, i >= tx_words.size(), cur_len), got);
        end
        master.deselect(cur_cspol);
        assert (oe_seen && !spi_miso_oe)
        else stop_fail("miso_oe did not follow the active part of the frame");
    endtask

    task automatic read_rx(input string name, input int n);
        logic [15:0] val;
        int          i;
        for (i = 0; i < n; i++) begin
            post({name, " rx len"}, 16'(cur_len), 16'(DUT.rx_head.char_len));
            host_read(reg_rxdata, val);
            post({name, " rx"}, expect_rx(mosi_words[i], cur_len, cur_rev), val);
        end
    endtask

    initial begin : main
        logic [31:0] r;
        logic [15:0] st;
        int          n;
        S_RESETN = 1'b0;
        wr       = 1'b0;
        rd       = 1'b0;
        addr     = 2'd0;
        wdata    = 16'd0;
        void'($urandom(92));
        repeat (10) @(posedge S_SYSCLK);
        #1;
        S_RESETN = 1'b1;

        configure(1'b0, 1'b0, 1'b1, 1'b1, 4'd7);     // mode 0, 8 bits, msb first
        tx_words.push_back(16'h00a5);
        mosi_words.push_back(16'h003c);
        run_frame("loopback", 1);
        read_rx("loopback", 1);

        for (n = 0; n < 40; n++) begin
            r = $urandom;
            configure(r[0], r[1], r[2], r[3], {r[5:4], 2'b11});
            tx_words.push_back(16'($urandom));
            mosi_words.push_back(16'($urandom));
            run_frame("random", 1);
            read_rx("random", 1);
        end

        configure(1'b1, 1'b1, 1'b0, 1'b0, 4'd11);
        for (n = 0; n < 3; n++) begin
            tx_words.push_back(16'($urandom));
            mosi_words.push_back(16'($urandom));
        end
        run_frame("multi", 3);
        host_read(reg_status, st);
        post("multi status", 16'h0003, st & 16'h0003);
        read_rx("multi", 3);

        configure(1'b0, 1'b0, 1'b1, 1'b1, 4'd7);
        host_write(reg_status, 16'h000c);
        mosi_words.push_back(16'h0055);
        run_frame("underrun", 1);
        host_read(reg_status, st);
        post("underrun set", 16'h0004, st & 16'h0004);
        host_write(reg_status, 16'h0004);
        host_read(reg_status, st);
        post("underrun clear", 16'h0000, st & 16'h0004);
        read_rx("underrun", 1);

        configure(1'b0, 1'b0, 1'b1, 1'b1, 4'd7);
        host_write(reg_status, 16'h000c);
        for (n = 0; n < rx_depth + 2; n++) begin
            if (n < tx_depth) begin
                tx_words.push_back(16'($urandom));
            end
            mosi_words.push_back(16'($urandom));
        end
        run_frame("overrun", rx_depth + 2);
        host_read(reg_status, st);
        post("overrun set", 16'h0008, st & 16'h0008);
        read_rx("overrun", rx_depth);

        host_write(reg_ctrl, 16'h00bb);
        host_read(reg_ctrl, st);
        post("ctrl readback", 16'h00bb, st);
        host_write(reg_ctrl, 16'h0045);     // length 5 is illegal
        host_read(reg_ctrl, st);
        post("ctrl bad length", 16'h0047, st);
        host_write(reg_ctrl, ctrl_word(1'b0));
        oe_seen = 1'b0;
        master.select(cur_cspol);
        master.xfer_char(cur_cpol, cur_cpha, cur_rev, cur_len, 16'h00f0, st);
        master.deselect(cur_cspol);
        host_read(reg_status, st);
        post("disabled rx", 16'h0000, st & 16'h0002);
        assert (!oe_seen) else stop_fail("miso_oe went high while the slave was disabled");

        repeat (2) @(posedge S_SYSCLK);     // checker drains the queue
        if (got_q.size() == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
rtl/espi_pkg.sv
rtl/espi_char_fifo.sv
rtl/espi_slave_regs.sv
rtl/espi_slave_char_trx.sv
rtl/espi_slave_top.sv
dv/espi_spi_master_model.sv
dv/tb_espi_slave.sv

//--- run_sim.sh
#!/bin/sh
# build the espi slave testbench with verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_espi_slave -f filelist.f --Mdir obj_dir -o Vtb_espi_slave
if [ $? -ne 0 ]; then
    echo "run_sim: verilator build failed"
    exit 1
fi

./obj_dir/Vtb_espi_slave > "$log" 2>&1
sim_status=$?
cat "$log"

if grep -q "FAIL: see errors above" "$log"; then
    echo "run_sim: simulation reported failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "run_sim: simulator exited with status $sim_status"
    exit 1
fi
echo "run_sim: simulation passed"
exit 0
